//--- design/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;

    localparam word_t reset_vector = 32'hbfc00000;  // first fetch address
    localparam logic [3:0] byte_en_all = 4'b1111;   // word accesses only

    // major opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // function codes of the r-type group
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;

    typedef enum logic [2:0] {
        s_fetch  = 3'd0,
        s_decode = 3'd1,
        s_exec   = 3'd2,
        s_mem    = 3'd3,
        s_wb     = 3'd4,
        s_halt   = 3'd5
    } state_t;

    // current owner of the shared bus
    typedef enum logic [1:0] {
        own_none  = 2'd0,
        own_fetch = 2'd1,
        own_lsu   = 2'd2
    } owner_t;

endpackage

//--- design/mips_pc.sv
`timescale 1ns/1ps

module mips_pc import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  advance,
    input  logic  take_target,
    input  word_t target,
    output word_t pc
);

    word_t pc_q;
    word_t target_q;   // destination waiting for the delay slot
    logic  pending;    // next advance passes the delay slot

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q    <= reset_vector;
            pending <= 1'b0;
        end else begin
            if (take_target) begin
                pending <= 1'b1;
            end
            // advance only pulses after a completed fetch, so stalls freeze pc
            if (advance) begin
                if (pending) begin
                    pc_q    <= target_q;  // slot fetched, redirect
                    pending <= 1'b0;
                end else begin
                    pc_q <= pc_q + 32'd4;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_target) begin
            target_q <= target;
        end
    end

    assign pc = pc_q;

endmodule

//--- design/mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  fetch_start,
    input  word_t pc,
    output logic  req,
    output word_t addr,
    input  logic  grant,
    input  logic  bus_done,
    input  word_t rdata,
    output word_t instr,
    output logic  done
);

    logic complete;

    assign complete = req && grant && bus_done;  // read accepted this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            req  <= 1'b0;
            done <= 1'b0;
        end else if (fetch_start) begin
            req  <= 1'b1;
            done <= 1'b0;
        end else if (complete) begin
            req  <= 1'b0;
            done <= 1'b1;  // held until next start
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            addr <= pc;
        end
        if (complete) begin
            instr <= rdata;  // instruction register
        end
    end

endmodule

//--- design/mips_lsu.sv
`timescale 1ns/1ps

module mips_lsu import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  mem_start,
    input  logic  is_store,
    input  word_t base_addr,
    input  word_t store_data,
    output logic  req,
    output logic  we,
    output word_t addr,
    output word_t wdata,
    input  logic  grant,
    input  logic  bus_done,
    input  word_t rdata,
    output word_t load_data,
    output logic  done
);

    logic complete;

    assign complete = req && grant && bus_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            req  <= 1'b0;
            we   <= 1'b0;
            done <= 1'b0;
        end else if (mem_start) begin
            req  <= 1'b1;
            we   <= is_store;
            done <= 1'b0;
        end else if (complete) begin
            req  <= 1'b0;
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) begin
            addr  <= base_addr;  // effective address from control
            wdata <= store_data;
        end
        if (complete && !we) begin
            load_data <= rdata;
        end
    end

endmodule

//--- design/mips_bus_arbiter.sv
`timescale 1ns/1ps

module mips_bus_arbiter import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       f_req,
    input  word_t      f_addr,
    output logic       f_grant,
    output logic       f_done,
    input  logic       l_req,
    input  logic       l_we,
    input  word_t      l_addr,
    input  word_t      l_wdata,
    output logic       l_grant,
    output logic       l_done,
    output word_t      rdata,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata,
    input  logic       waitrequest
);

    owner_t owner;

    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= own_none;
        end else begin
            case (owner)
                own_none: begin
                    if (l_req) begin
                        owner <= own_lsu;  // lsu wins a tie
                    end else if (f_req) begin
                        owner <= own_fetch;
                    end
                end
                own_fetch: if (f_done) owner <= own_none;
                own_lsu:   if (l_done) owner <= own_none;
                default:   owner <= own_none;
            endcase
        end
    end

    assign f_grant = (owner == own_fetch);
    assign l_grant = (owner == own_lsu);

    assign f_done = f_grant && f_req && !waitrequest;
    assign l_done = l_grant && l_req && !waitrequest;

    assign read       = (f_grant && f_req) || (l_grant && l_req && !l_we);
    assign write      = l_grant && l_req && l_we;
    assign address    = l_grant ? l_addr : f_addr;
    assign writedata  = l_wdata;
    assign byteenable = byte_en_all;
    assign rdata      = readdata;  // shared return path to both peers

endmodule

//--- design/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] rs,
    input  logic [4:0] rt,
    output word_t      rd_a,
    output word_t      rd_b,
    input  logic       we,
    input  logic [4:0] wa,
    input  word_t      wd,
    output word_t      register_v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;  // r0 never written
        end
    end

    assign rd_a = (rs == 5'd0) ? '0 : regs[rs];
    assign rd_b = (rt == 5'd0) ? '0 : regs[rt];

    assign register_v0 = regs[2];

endmodule

//--- design/mips_core_ctrl.sv
`timescale 1ns/1ps

module mips_core_ctrl import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  word_t      instr,
    input  word_t      pc,
    input  logic       fetch_done,
    input  logic       lsu_done,
    input  word_t      load_data,
    input  word_t      rd_a,
    input  word_t      rd_b,
    output logic [4:0] rs,
    output logic [4:0] rt,
    output logic       reg_we,
    output logic [4:0] reg_wa,
    output word_t      reg_wd,
    output logic       fetch_start,
    output logic       mem_start,
    output logic       is_store,
    output word_t      mem_addr,
    output word_t      store_data,
    output logic       advance,
    output logic       take_target,
    output word_t      target,
    output logic       active
);

    state_t     state;
    word_t      ir;            // copy that survives the prefetch
    logic       fetch_issued;
    logic       mem_issued;
    logic       jump_zero;     // a jump went to address 0
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rd;
    word_t      simm;
    word_t      alu_result;
    logic       alu_we;
    logic [4:0] alu_wa;
    logic       is_jump;
    logic       taken;
    logic       is_mem;
    logic       halt_now;

    assign opcode = ir[31:26];
    assign funct  = ir[5:0];
    assign rs     = ir[25:21];
    assign rt     = ir[20:16];
    assign rd     = ir[15:11];
    assign simm   = {{16{ir[15]}}, ir[15:0]};

    always_comb begin
        alu_result = '0;
        alu_we     = 1'b0;
        alu_wa     = rt;
        is_jump    = 1'b0;
        taken      = 1'b0;
        target     = pc + {simm[29:0], 2'b00};  // pc already points at the slot
        case (opcode)
            op_rtype: begin
                alu_wa = rd;
                alu_we = (funct == fn_addu) || (funct == fn_subu) ||
                         (funct == fn_and) || (funct == fn_or);
                case (funct)
                    fn_addu: alu_result = rd_a + rd_b;
                    fn_subu: alu_result = rd_a - rd_b;
                    fn_and:  alu_result = rd_a & rd_b;
                    fn_or:   alu_result = rd_a | rd_b;
                    fn_jr: begin
                        is_jump = 1'b1;
                        target  = rd_a;
                    end
                    default: alu_result = '0;
                endcase
            end
            op_addiu: begin
                alu_result = rd_a + simm;
                alu_we     = 1'b1;
            end
            op_lui: begin
                alu_result = {ir[15:0], 16'h0000};
                alu_we     = 1'b1;
            end
            op_beq: taken = (rd_a == rd_b);
            op_bne: taken = (rd_a != rd_b);
            op_j: begin
                is_jump = 1'b1;
                target  = {pc[31:28], ir[25:0], 2'b00};
            end
            default: alu_we = 1'b0;  // everything else is a nop
        endcase
    end

    assign is_mem     = (opcode == op_lw) || (opcode == op_sw);
    assign is_store   = (opcode == op_sw);
    assign mem_addr   = rd_a + simm;
    assign store_data = rd_b;
    assign halt_now   = jump_zero && (pc == '0);

    assign advance     = (state == s_fetch) && fetch_issued && !fetch_start && fetch_done;
    assign take_target = (state == s_exec) && (taken || is_jump);
    assign reg_we      = ((state == s_exec) && alu_we) || (state == s_wb);
    assign reg_wa      = (state == s_wb) ? rt : alu_wa;
    assign reg_wd      = (state == s_wb) ? load_data : alu_result;
    assign active      = (state != s_halt);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= s_fetch;
            fetch_issued <= 1'b0;
            mem_issued   <= 1'b0;
            jump_zero    <= 1'b0;
            fetch_start  <= 1'b0;
            mem_start    <= 1'b0;
        end else begin
            fetch_start <= 1'b0;
            mem_start   <= 1'b0;
            case (state)
                s_fetch: begin
                    if (!fetch_issued) begin
                        if (halt_now) begin
                            state <= s_halt;  // slot done, nothing more to fetch
                        end else begin
                            fetch_start  <= 1'b1;
                            fetch_issued <= 1'b1;
                        end
                    end else if (advance) begin
                        fetch_issued <= 1'b0;
                        state        <= s_decode;
                    end
                end
                s_decode: state <= s_exec;
                s_exec: begin
                    if (is_jump && (target == '0)) begin
                        jump_zero <= 1'b1;
                    end
                    state <= is_mem ? s_mem : s_fetch;
                end
                s_mem: begin
                    if (!mem_issued) begin
                        mem_start  <= 1'b1;
                        mem_issued <= 1'b1;
                        if (!halt_now) begin
                            fetch_start  <= 1'b1;  // prefetch next instruction
                            fetch_issued <= 1'b1;
                        end
                    end else if (!mem_start && lsu_done) begin
                        mem_issued <= 1'b0;
                        state      <= (opcode == op_lw) ? s_wb : s_fetch;
                    end
                end
                s_wb:    state <= s_fetch;
                s_halt:  state <= s_halt;
                default: state <= s_halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_decode) begin
            ir <= instr;
        end
    end

endmodule

//--- design/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata,
    input  logic       waitrequest,
    output logic       active,
    output word_t      register_v0
);

    word_t      pc;
    word_t      target;
    logic       advance;
    logic       take_target;
    logic       fetch_start;
    logic       fetch_done;
    word_t      instr;
    logic       f_req;
    word_t      f_addr;
    logic       f_grant;
    logic       f_done;
    logic       mem_start;
    logic       lsu_done;
    logic       is_store;
    word_t      mem_addr;
    word_t      store_data;
    word_t      load_data;
    logic       l_req;
    logic       l_we;
    word_t      l_addr;
    word_t      l_wdata;
    logic       l_grant;
    logic       l_done;
    word_t      bus_rdata;
    logic [4:0] rs;
    logic [4:0] rt;
    word_t      rd_a;
    word_t      rd_b;
    logic       reg_we;
    logic [4:0] reg_wa;
    word_t      reg_wd;

    mips_pc u_pc (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .take_target (take_target),
        .target      (target),
        .pc          (pc)
    );

    mips_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_start (fetch_start),
        .pc          (pc),
        .req         (f_req),
        .addr        (f_addr),
        .grant       (f_grant),
        .bus_done    (f_done),
        .rdata       (bus_rdata),
        .instr       (instr),
        .done        (fetch_done)
    );

    mips_lsu u_lsu (
        .clk        (clk),
        .reset      (reset),
        .mem_start  (mem_start),
        .is_store   (is_store),
        .base_addr  (mem_addr),
        .store_data (store_data),
        .req        (l_req),
        .we         (l_we),
        .addr       (l_addr),
        .wdata      (l_wdata),
        .grant      (l_grant),
        .bus_done   (l_done),
        .rdata      (bus_rdata),
        .load_data  (load_data),
        .done       (lsu_done)
    );

    mips_bus_arbiter u_arb (
        .clk         (clk),
        .reset       (reset),
        .f_req       (f_req),
        .f_addr      (f_addr),
        .f_grant     (f_grant),
        .f_done      (f_done),
        .l_req       (l_req),
        .l_we        (l_we),
        .l_addr      (l_addr),
        .l_wdata     (l_wdata),
        .l_grant     (l_grant),
        .l_done      (l_done),
        .rdata       (bus_rdata),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    mips_regfile u_regs (
        .clk         (clk),
        .reset       (reset),
        .rs          (rs),
        .rt          (rt),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .we          (reg_we),
        .wa          (reg_wa),
        .wd          (reg_wd),
        .register_v0 (register_v0)
    );

    mips_core_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .pc          (pc),
        .fetch_done  (fetch_done),
        .lsu_done    (lsu_done),
        .load_data   (load_data),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .rs          (rs),
        .rt          (rt),
        .reg_we      (reg_we),
        .reg_wa      (reg_wa),
        .reg_wd      (reg_wd),
        .fetch_start (fetch_start),
        .mem_start   (mem_start),
        .is_store    (is_store),
        .mem_addr    (mem_addr),
        .store_data  (store_data),
        .advance     (advance),
        .take_target (take_target),
        .target      (target),
        .active      (active)
    );

endmodule

//--- verification/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
    parameter logic [31:0] code_base = 32'hbfc00000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic        waitrequest
);

    logic [31:0] code_mem [64];  // 256 bytes at code_base
    logic [31:0] data_mem [64];  // 256 bytes at address 0
    integer      seed = 32'hc1c3;
    int          stall_left = 0;
    logic        wait_q = 1'b1;
    logic        code_sel;
    logic        data_sel;

    assign code_sel    = (address[31:8] == code_base[31:8]);
    assign data_sel    = (address[31:8] == 24'h000000);
    assign waitrequest = wait_q;

    always_comb begin
        if (code_sel) begin
            readdata = code_mem[address[7:2]];
        end else if (data_sel) begin
            readdata = data_mem[address[7:2]];
        end else begin
            readdata = 32'h0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                data_mem[i] = 32'h5aa5_0000 ^ 32'(i * 4);  // byte address in low bits
            end
            stall_left = $unsigned($random(seed)) % 4;
        end else if (read || write) begin
            if (wait_q) begin
                stall_left = stall_left - 1;  // one stall cycle used up
            end else begin
                if (write && data_sel) begin
                    data_mem[address[7:2]] = writedata;
                end
                stall_left = $unsigned($random(seed)) % 4;  // stalls of the next access
            end
        end
        #1;
        wait_q = (stall_left != 0);
    end

endmodule

//--- verification/tb_mips_cpu.sv
`timescale 1ns/1ps

module tb_mips_cpu;

    localparam logic [31:0] boot_addr   = 32'hbfc00000;
    localparam logic [5:0]  opc_special = 6'h00;
    localparam logic [5:0]  opc_beq     = 6'h04;
    localparam logic [5:0]  opc_bne     = 6'h05;
    localparam logic [5:0]  opc_addiu   = 6'h09;
    localparam logic [5:0]  opc_lui     = 6'h0f;
    localparam logic [5:0]  opc_lw      = 6'h23;
    localparam logic [5:0]  opc_sw      = 6'h2b;
    localparam logic [5:0]  fnc_jr      = 6'h08;
    localparam logic [5:0]  fnc_addu    = 6'h21;
    localparam logic [5:0]  fnc_subu    = 6'h23;
    localparam logic [5:0]  fnc_and     = 6'h24;
    localparam logic [5:0]  fnc_or      = 6'h25;
    localparam logic [15:0] k_hi        = 16'h1234;
    localparam logic [15:0] k_lo        = 16'h5678;
    localparam logic [15:0] k_neg       = 16'hfff0;
    localparam logic [15:0] k_mask      = 16'h0f0f;
    localparam logic [15:0] k_data_hi   = 16'hcafe;
    localparam logic [15:0] k_data_lo   = 16'h1234;
    localparam logic [15:0] k_base      = 16'h0050;
    localparam logic [15:0] k_off       = 16'hfff0;
    localparam logic [15:0] k_slot      = 16'h0001;
    localparam logic [15:0] k_seq       = 16'h0010;
    localparam logic [15:0] k_skip      = 16'h0100;
    localparam logic [15:0] k_far       = 16'h1000;
    localparam int          start_limit = 64;
    localparam int          halt_limit  = 4000;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    logic        waitrequest;
    logic        active;
    logic [31:0] register_v0;

    logic [31:0] prog [$];
    logic [31:0] skip_addr = 32'hffff_fffc;  // fetch address that must never appear
    int          data_count = 0;
    logic [31:0] wr_addr = '0;
    logic [31:0] wr_data = '0;

    always #5 clk = ~clk;

    mips_cpu u_mips_cpu (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .active      (active),
        .register_v0 (register_v0)
    );

    tb_mem_model #(.code_base(boot_addr)) u_mem (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] fn);
        return {opc_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic in_code_region(input logic [31:0] a);
        return a[31:8] == boot_addr[31:8];
    endfunction

    function automatic logic is_data_addr(input logic [31:0] a);
        return a[31:8] == 24'h000000;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
            else abort_run($sformatf("mismatch %s got %h expected %h", name, got, want));
    endtask

    // completed accesses seen on the bus
    always @(posedge clk) begin
        if (reset) begin
            data_count <= 0;
        end else if ((read || write) && !waitrequest) begin
            if (is_data_addr(address)) begin
                data_count <= data_count + 1;
            end
            if (write) begin
                wr_addr <= address;
                wr_data <= writedata;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else abort_run("read and write strobes high in the same cycle");
    assert property (@(posedge clk) disable iff (reset) (read || write) |-> byteenable == 4'hf)
        else abort_run($sformatf("mismatch byteenable got %h expected f", byteenable));
    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else abort_run("address or strobe changed while waitrequest was high");
    assert property (@(posedge clk) disable iff (reset) write && waitrequest |=> $stable(writedata))
        else abort_run("writedata changed while waitrequest was high");
    assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> in_code_region(address) || is_data_addr(address))
        else abort_run($sformatf("bus access outside both regions at %h", address));
    assert property (@(posedge clk) disable iff (reset) read |-> address != skip_addr)
        else abort_run("instruction after a taken branch slot was fetched");
    assert property (@(posedge clk) disable iff (reset) !active |-> !read && !write)
        else abort_run("bus strobe after the core halted");

    task automatic load_code;
        for (int i = 0; i < 64; i++) begin
            u_mem.code_mem[i] = (i < prog.size()) ? prog[i] : 32'h0;  // nop past the end
        end
    endtask

    task automatic run_program(input logic [31:0] want_v0, input logic [31:0] want_data);
        int cycles;
        reset = 1'b1;
        load_code();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (active === 1'b1) else abort_run("active is low after reset");
        cycles = 0;
        while (!read) begin
            if (cycles == start_limit) abort_run("timeout waiting for the first read strobe");
            tick();
            cycles++;
        end
        expect_word("address", address, boot_addr);
        cycles = 0;
        while (active) begin
            if (cycles == halt_limit) abort_run("timeout waiting for active to fall");
            tick();
            cycles++;
        end
        repeat (8) tick();  // quiet window after halt
        expect_word("register_v0", register_v0, want_v0);
        expect_word("data_count", data_count, want_data);
    endtask

    initial begin
        logic [31:0] r3;
        logic [31:0] r5;
        logic [31:0] r6;
        logic [31:0] want;
        logic [31:0] st_addr;

        // arithmetic
        r3 = {k_hi, 16'h0000} + sext16(k_lo);
        r5 = r3 & sext16(k_neg);
        r6 = r5 | sext16(k_mask);
        want = (r6 - r3) + r5;
        prog.delete();
        prog.push_back(itype_word(opc_lui, 5'd0, 5'd3, k_hi));
        prog.push_back(itype_word(opc_addiu, 5'd3, 5'd3, k_lo));
        prog.push_back(itype_word(opc_addiu, 5'd0, 5'd4, k_neg));
        prog.push_back(rtype_word(5'd3, 5'd4, 5'd5, fnc_and));
        prog.push_back(itype_word(opc_addiu, 5'd0, 5'd7, k_mask));
        prog.push_back(rtype_word(5'd5, 5'd7, 5'd6, fnc_or));
        prog.push_back(rtype_word(5'd6, 5'd3, 5'd8, fnc_subu));
        prog.push_back(rtype_word(5'd8, 5'd5, 5'd2, fnc_addu));
        prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, fnc_jr));
        prog.push_back(32'h0);
        run_program(want, 32'd0);

        // store then reload through a negative offset
        want = {k_data_hi, 16'h0000} + sext16(k_data_lo);
        st_addr = sext16(k_base) + sext16(k_off);
        prog.delete();
        prog.push_back(itype_word(opc_lui, 5'd0, 5'd3, k_data_hi));
        prog.push_back(itype_word(opc_addiu, 5'd3, 5'd3, k_data_lo));
        prog.push_back(itype_word(opc_addiu, 5'd0, 5'd4, k_base));
        prog.push_back(itype_word(opc_sw, 5'd4, 5'd3, k_off));
        prog.push_back(itype_word(opc_lw, 5'd0, 5'd2, st_addr[15:0]));
        prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, fnc_jr));
        prog.push_back(32'h0);
        run_program(want, 32'd2);
        expect_word("wr_addr", wr_addr, st_addr);
        expect_word("wr_data", wr_data, want);
        expect_word("u_mem.data_mem", u_mem.data_mem[st_addr[7:2]], want);

        // branches with delay slots
        want = sext16(k_slot) + sext16(k_seq) + sext16(k_slot) + sext16(k_far);
        skip_addr = boot_addr + 32'd32;  // word 8 sits right after the beq slot
        prog.delete();
        prog.push_back(itype_word(opc_addiu, 5'd0, 5'd2, 16'h0000));
        prog.push_back(itype_word(opc_addiu, 5'd0, 5'd3, 16'h0005));
        prog.push_back(itype_word(opc_addiu, 5'd0, 5'd4, 16'h0005));
        prog.push_back(itype_word(opc_bne, 5'd3, 5'd4, 16'd4));  // not taken
        prog.push_back(itype_word(opc_addiu, 5'd2, 5'd2, k_slot));
        prog.push_back(itype_word(opc_addiu, 5'd2, 5'd2, k_seq));
        prog.push_back(itype_word(opc_beq, 5'd3, 5'd4, 16'd2));  // taken to word 9
        prog.push_back(itype_word(opc_addiu, 5'd2, 5'd2, k_slot));
        prog.push_back(itype_word(opc_addiu, 5'd2, 5'd2, k_skip));
        prog.push_back(itype_word(opc_addiu, 5'd2, 5'd2, k_far));
        prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, fnc_jr));
        prog.push_back(32'h0);
        run_program(want, 32'd0);

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- build.f
design/mips_pkg.sv
design/mips_pc.sv
design/mips_fetch.sv
design/mips_lsu.sv
design/mips_bus_arbiter.sv
design/mips_regfile.sv
design/mips_core_ctrl.sv
design/mips_cpu.sv
verification/tb_mem_model.sv
verification/tb_mips_cpu.sv

//--- Makefile
# Verilator flow for the multicycle MIPS core
# every variable below can be overridden on the command line

VERILATOR  ?= verilator
FILELIST   ?= build.f
TOP        ?= tb_mips_cpu
RTL_TOP    ?= mips_cpu
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TB PASSED
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

RTL_SRCS := $(filter design/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
